// File: lvds_tx_pkg.sv
// shared types for the lvds transmit interface
//   tap width and delay tap type
//   lane bit pair sent in one tx_clk cycle
//   per-lane tap load strobe and value
//   delay reference controller states

package lvds_tx_pkg;

  // **************************************************
  // delay tap
  // **************************************************

  // tap counts whole tx_clk cycles of extra output delay
  localparam int TAP_W = 5;

  // 0 to 31 cycles
  typedef logic [TAP_W-1:0] delay_tap_t;

  // **************************************************
  // lane data
  // **************************************************

  // rise goes out in the high half of tx_clk, fall in the low half
  typedef struct packed {
    logic rise;
    logic fall;
  } lvds_bit_pair_t;

  // **************************************************
  // tap load
  // **************************************************

  // ld is a one-cycle strobe in the up_clk domain
  typedef struct packed {
    logic       ld;
    delay_tap_t tap;
  } lane_load_t;

  // **************************************************
  // delay controller
  // **************************************************

  typedef enum logic [1:0] {
    LOCK_RESET = 2'd0,
    LOCK_WAIT  = 2'd1,
    LOCK_DONE  = 2'd2
  } lock_state_t;

endpackage

// File: tx_frame_fmt.sv
// parallel sample formatter for the lvds transmit interface
//   splits each sample into per-lane rise/fall bit pairs
//   adds the frame lane built from tx_valid
//   blanks the data lanes while tx_valid is low

`timescale 1ns/1ps

module tx_frame_fmt
  import lvds_tx_pkg::*;
#(
  parameter int NUM_LANES = 4
) (
  input  logic                             tx_clk,
  input  logic                             arst_n,

  // parallel sample, two bits per data lane
  input  logic                             tx_valid,
  input  logic [2*NUM_LANES-1:0]           tx_sample,

  // data lanes 0..NUM_LANES-1, frame lane at NUM_LANES
  output lvds_bit_pair_t [NUM_LANES:0]     lane_pair
);

  // next pairs, before the register
  lvds_bit_pair_t [NUM_LANES:0] pair_d;

  // **************************************************
  // lane split
  // **************************************************

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      // odd bit leaves on the rising edge, even bit on the falling edge
      pair_d[i].rise = tx_valid & tx_sample[2*i+1];
      pair_d[i].fall = tx_valid & tx_sample[2*i];
    end

    // frame lane marks valid cycles with a 1/0 pattern
    pair_d[NUM_LANES].rise = tx_valid;
    pair_d[NUM_LANES].fall = 1'b0;
  end

  // **************************************************
  // sample register
  // **************************************************

  // one tx_clk cycle from sample to pairs
  // cleared so the lanes idle low out of reset
  always_ff @(posedge tx_clk or negedge arst_n) begin
    if (!arst_n) begin
      lane_pair <= '0;
    end else begin
      lane_pair <= pair_d;
    end
  end

endmodule

// File: lvds_out.sv
// one lvds transmit lane
//   ddr capture of the lane bit pair
//   32-stage delay line, stage picked by the tap
//   tap register in the up_clk domain with readback
//   ddr output mux and p/n output driver

`timescale 1ns/1ps

module lvds_out
  import lvds_tx_pkg::*;
#(
  parameter int SINGLE_ENDED   = 0,
  parameter int IODELAY_ENABLE = 1
) (
  input  logic           tx_clk,
  input  logic           up_clk,
  input  logic           arst_n,

  // bit pair from the formatter
  input  lvds_bit_pair_t pair,

  // tap load and current tap
  input  lane_load_t     load,
  output delay_tap_t     tap,

  // lane pins
  output logic           out_p,
  output logic           out_n
);

  localparam int NUM_STAGES = 2 ** TAP_W;

  // tap in use, up_clk domain
  delay_tap_t                      tap_q;

  // delay line, stage 0 is the capture register
  lvds_bit_pair_t [NUM_STAGES-1:0] dly_q;
  lvds_bit_pair_t                  dly_sel;

  // ddr output register and mux
  lvds_bit_pair_t                  oddr_q;
  logic                            ddr_out;

  // **************************************************
  // tap register
  // **************************************************

  generate
    if (IODELAY_ENABLE == 1) begin : g_odelay
      // loads at the up_clk edge that sees the strobe
      always_ff @(posedge up_clk or negedge arst_n) begin
        if (!arst_n) begin
          tap_q <= '0;
        end else if (load.ld) begin
          tap_q <= load.tap;
        end
      end
    end else begin : g_no_odelay
      // no delay line in use, tap stays 0
      assign tap_q = '0;
    end
  endgenerate

  // readback of the tap in use
  assign tap = tap_q;

  // **************************************************
  // delay line
  // **************************************************

  // shifts every tx_clk cycle, new pair enters at stage 0
  always_ff @(posedge tx_clk or negedge arst_n) begin
    if (!arst_n) begin
      dly_q <= '0;
    end else begin
      dly_q <= {dly_q[NUM_STAGES-2:0], pair};
    end
  end

  // taps are quasi-static, changed only while the lane is idle
  assign dly_sel = dly_q[tap_q];

  // **************************************************
  // ddr output stage
  // **************************************************

  // oddr register, both bits taken on the rising edge
  always_ff @(posedge tx_clk or negedge arst_n) begin
    if (!arst_n) begin
      oddr_q <= '0;
    end else begin
      oddr_q <= dly_sel;
    end
  end

  // high half sends rise, low half sends fall
  assign ddr_out = tx_clk ? oddr_q.rise : oddr_q.fall;

  // output driver
  generate
    if (SINGLE_ENDED == 1) begin : g_single
      // n pin unused in single-ended mode
      assign out_p = ddr_out;
      assign out_n = 1'b0;
    end else begin : g_diff
      assign out_p = ddr_out;
      assign out_n = ~ddr_out;
    end
  endgenerate

endmodule

// File: delay_ctrl.sv
// delay reference controller model
//   lock state machine with a down-counter on delay_clk
//   delay_locked tied high when the controller is not used

`timescale 1ns/1ps

module delay_ctrl
  import lvds_tx_pkg::*;
#(
  parameter int DELAY_CTRL_ENABLE = 1,
  parameter int LOCK_CYCLES       = 12
) (
  input  logic delay_clk,
  input  logic arst_n,
  input  logic delay_rst,
  output logic delay_locked
);

  localparam int CNT_W = $clog2(LOCK_CYCLES + 1);

  generate
    if (DELAY_CTRL_ENABLE == 1) begin : g_ctrl
      lock_state_t      state_q;
      logic [CNT_W-1:0] cnt_q;

      // **************************************************
      // lock fsm
      // **************************************************

      always_ff @(posedge delay_clk or negedge arst_n) begin
        if (!arst_n) begin
          state_q <= LOCK_RESET;
          cnt_q   <= '0;
        end else if (delay_rst) begin
          // drop lock on the next edge whatever the state
          state_q <= LOCK_RESET;
          cnt_q   <= '0;
        end else begin
          case (state_q)
            LOCK_RESET: begin
              state_q <= LOCK_WAIT;
              cnt_q   <= CNT_W'(LOCK_CYCLES - 1);
            end
            LOCK_WAIT: begin
              if (cnt_q == '0) begin
                state_q <= LOCK_DONE;
              end else begin
                cnt_q <= cnt_q - 1'b1;
              end
            end
            LOCK_DONE: begin
              state_q <= LOCK_DONE;
            end
            default: begin
              state_q <= LOCK_RESET;
            end
          endcase
        end
      end

      assign delay_locked = (state_q == LOCK_DONE);
    end else begin : g_no_ctrl
      // no controller, always locked
      assign delay_locked = 1'b1;
    end
  endgenerate

endmodule

// File: up_delay_regs.sv
// processor-side delay tap access
//   write decode into per-lane tap load strobes
//   writes dropped while the delay controller is unlocked
//   registered tap readback, out-of-range lanes read 0

`timescale 1ns/1ps

module up_delay_regs
  import lvds_tx_pkg::*;
#(
  parameter int  NUM_LANES = 4,
  localparam int LANE_AW   = $clog2(NUM_LANES + 1)
) (
  input  logic                       up_clk,
  input  logic                       arst_n,

  // write port
  input  logic                       up_wr,
  input  logic [LANE_AW-1:0]         up_waddr,
  input  delay_tap_t                 up_wdata,

  // read port
  input  logic [LANE_AW-1:0]         up_raddr,
  output delay_tap_t                 up_rdata,

  // lock from the delay controller
  input  logic                       delay_locked,

  // lane side, frame lane included
  input  delay_tap_t [NUM_LANES:0]   lane_tap,
  output lane_load_t [NUM_LANES:0]   lane_load
);

  // write accepted this cycle
  logic       wr_ok;

  // tap picked by the read address
  delay_tap_t rd_mux;

  // **************************************************
  // write decode
  // **************************************************

  // in range and locked, otherwise the write is lost
  assign wr_ok = up_wr & delay_locked & (up_waddr <= LANE_AW'(NUM_LANES));

  // strobe is as long as up_wr, the lane loads on that same edge
  always_comb begin
    for (int i = 0; i <= NUM_LANES; i++) begin
      lane_load[i].ld  = wr_ok & (up_waddr == LANE_AW'(i));
      lane_load[i].tap = up_wdata;
    end
  end

  // **************************************************
  // readback
  // **************************************************

  // addresses past the frame lane match nothing and give 0
  always_comb begin
    rd_mux = '0;
    for (int i = 0; i <= NUM_LANES; i++) begin
      if (up_raddr == LANE_AW'(i)) begin
        rd_mux = lane_tap[i];
      end
    end
  end

  // one up_clk cycle from address to data
  always_ff @(posedge up_clk or negedge arst_n) begin
    if (!arst_n) begin
      up_rdata <= '0;
    end else begin
      up_rdata <= rd_mux;
    end
  end

endmodule

// File: lvds_tx_if.sv
// source-synchronous lvds transmit interface, top level
//   sample formatter feeding NUM_LANES data lanes and a frame lane
//   one lvds_out per lane with its own output delay
//   processor-side tap registers and delay reference controller

`timescale 1ns/1ps

module lvds_tx_if
  import lvds_tx_pkg::*;
#(
  parameter int  NUM_LANES         = 4,
  parameter int  SINGLE_ENDED      = 0,
  parameter int  IODELAY_ENABLE    = 1,
  parameter int  DELAY_CTRL_ENABLE = 1,
  parameter int  LOCK_CYCLES       = 12,
  localparam int LANE_AW           = $clog2(NUM_LANES + 1)
) (
  input  logic                     tx_clk,
  input  logic                     up_clk,
  input  logic                     delay_clk,
  input  logic                     arst_n,

  // parallel sample in
  input  logic                     tx_valid,
  input  logic [2*NUM_LANES-1:0]   tx_sample,

  // lane pins, frame lane on the top bit
  output logic [NUM_LANES:0]       tx_data_out_p,
  output logic [NUM_LANES:0]       tx_data_out_n,

  // processor tap interface
  input  logic                     up_wr,
  input  logic [LANE_AW-1:0]       up_waddr,
  input  delay_tap_t               up_wdata,
  input  logic [LANE_AW-1:0]       up_raddr,
  output delay_tap_t               up_rdata,

  // delay reference controller
  input  logic                     delay_rst,
  output logic                     delay_locked
);

  // formatter to lanes
  lvds_bit_pair_t [NUM_LANES:0] lane_pair;

  // tap registers to lanes and back
  lane_load_t     [NUM_LANES:0] lane_load;
  delay_tap_t     [NUM_LANES:0] lane_tap;

  // **************************************************
  // sample formatter
  // **************************************************

  tx_frame_fmt #(
    .NUM_LANES (NUM_LANES)
  ) u_frame_fmt (
    .tx_clk    (tx_clk),
    .arst_n    (arst_n),
    .tx_valid  (tx_valid),
    .tx_sample (tx_sample),
    .lane_pair (lane_pair)
  );

  // **************************************************
  // lanes
  // **************************************************

  // lane NUM_LANES carries the frame
  for (genvar i = 0; i <= NUM_LANES; i++) begin : g_lane
    lvds_out #(
      .SINGLE_ENDED   (SINGLE_ENDED),
      .IODELAY_ENABLE (IODELAY_ENABLE)
    ) u_lane (
      .tx_clk (tx_clk),
      .up_clk (up_clk),
      .arst_n (arst_n),
      .pair   (lane_pair[i]),
      .load   (lane_load[i]),
      .tap    (lane_tap[i]),
      .out_p  (tx_data_out_p[i]),
      .out_n  (tx_data_out_n[i])
    );
  end

  // **************************************************
  // tap registers and delay controller
  // **************************************************

  up_delay_regs #(
    .NUM_LANES (NUM_LANES)
  ) u_up_regs (
    .up_clk       (up_clk),
    .arst_n       (arst_n),
    .up_wr        (up_wr),
    .up_waddr     (up_waddr),
    .up_wdata     (up_wdata),
    .up_raddr     (up_raddr),
    .up_rdata     (up_rdata),
    .delay_locked (delay_locked),
    .lane_tap     (lane_tap),
    .lane_load    (lane_load)
  );

  delay_ctrl #(
    .DELAY_CTRL_ENABLE (DELAY_CTRL_ENABLE),
    .LOCK_CYCLES       (LOCK_CYCLES)
  ) u_delay_ctrl (
    .delay_clk    (delay_clk),
    .arst_n       (arst_n),
    .delay_rst    (delay_rst),
    .delay_locked (delay_locked)
  );

endmodule

// File: lvds_tx_checker.sv
// output checker for the lvds transmit interface testbench
//   samples the lane pins in the high and low half of tx_clk
//   compares lanes, out_n polarity, delay_locked and up_rdata with the model
//   prints one line per test and the closing counts

`timescale 1ns/1ps

module lvds_tx_checker
  import lvds_tx_pkg::*;
#(
  parameter int NUM_LANES    = 4,
  parameter int SINGLE_ENDED = 0
) (
  input  logic                         tx_clk,

  // dut side
  input  logic [NUM_LANES:0]           tx_data_out_p,
  input  logic [NUM_LANES:0]           tx_data_out_n,
  input  delay_tap_t                   up_rdata,
  input  logic                         delay_locked,

  // model side, valid for the current tx_clk period
  input  logic [NUM_LANES:0]           exp_en,
  input  lvds_bit_pair_t [NUM_LANES:0] exp_pair,
  input  logic                         rd_en,
  input  delay_tap_t                   rd_exp,
  input  logic                         lock_exp,

  // test bookkeeping
  input  int                           test_id,
  input  logic                         test_done,
  input  logic                         run_done,
  output int                           err_cnt,
  output int                           chk_cnt
);

  int chk_base;
  int err_base;

  function automatic string test_name(input int id);
    case (id)
      0: test_name = "reset_idle";
      1: test_name = "lock_gate";
      2: test_name = "stream_tap0";
      3: test_name = "tap_readback";
      4: test_name = "stream_delayed";
      5: test_name = "relock";
      default: test_name = "unknown";
    endcase
  endfunction

  task automatic compare(input string what, input logic [31:0] exp_v,
                         input logic [31:0] act_v);
    chk_cnt = chk_cnt + 1;
    if (act_v !== exp_v) begin
      err_cnt = err_cnt + 1;
      $display("FAIL %s %s: expected %0h, actual %0h at %0t ns",
               test_name(test_id), what, exp_v, act_v, $time);
    end
  endtask

  // hi picks the rise bit, otherwise the fall bit
  task automatic check_half(input logic hi);
    logic exp_b;
    logic n_exp;
    for (int i = 0; i <= NUM_LANES; i++) begin
      if (exp_en[i]) begin
        exp_b = hi ? exp_pair[i].rise : exp_pair[i].fall;
        compare($sformatf("lane %0d %s", i, hi ? "rise" : "fall"), exp_b, tx_data_out_p[i]);
      end
      // n pin follows p in every half, data or idle
      if (SINGLE_ENDED == 1) begin
        n_exp = 1'b0;
      end else begin
        n_exp = ~tx_data_out_p[i];
      end
      compare($sformatf("lane %0d out_n", i), n_exp, tx_data_out_n[i]);
    end
  endtask

  initial begin
    err_cnt  = 0;
    chk_cnt  = 0;
    chk_base = 0;
    err_base = 0;
  end

  // **************************************************
  // sampling
  // **************************************************

  // middle of the high half, then middle of the low half
  always @(posedge tx_clk) begin
    #25;
    check_half(1'b1);
    compare("delay_locked", lock_exp, delay_locked);
    if (rd_en) begin
      compare("up_rdata", rd_exp, up_rdata);
    end
    #50;
    check_half(1'b0);
  end

  always @(posedge test_done) begin
    $display("%s done: %0d checks, %0d errors", test_name(test_id),
             chk_cnt - chk_base, err_cnt - err_base);
    chk_base = chk_cnt;
    err_base = err_cnt;
  end

  always @(posedge run_done) begin
    $display("total: %0d checks, %0d errors", chk_cnt, err_cnt);
  end

endmodule

// File: tb_lvds_tx_if.sv
// testbench for the lvds transmit interface
//   clock, reset and seeded random stimulus
//   model queue of expected lane pairs tagged with their due cycle
//   test sequence, checker instance and watchdog

`timescale 1ns/1ps

module tb_lvds_tx_if
  import lvds_tx_pkg::*;
();

  localparam int NUM_LANES         = 4;
  localparam int SINGLE_ENDED      = 0;
  localparam int IODELAY_ENABLE    = 1;
  localparam int DELAY_CTRL_ENABLE = 1;
  localparam int LOCK_CYCLES       = 12;
  localparam int LANE_AW           = $clog2(NUM_LANES + 1);
  localparam int N_SAMPLES         = 300;
  // reset, idle, lock, two streams with drain, tap access, relock
  localparam int TEST_CYCLES = 10 + 2 * LOCK_CYCLES + 15 + 2 * N_SAMPLES + 78
                             + 2 * (NUM_LANES + 1) + 3;

  // expected pair for one lane at one cycle
  typedef struct packed {
    logic [31:0]    due;
    logic [7:0]     lane;
    lvds_bit_pair_t pair;
  } model_ent_t;

  logic tx_clk;
  logic up_clk;
  logic delay_clk;
  logic arst_n;
  logic tx_valid;
  logic [2*NUM_LANES-1:0] tx_sample;
  logic [NUM_LANES:0] tx_data_out_p;
  logic [NUM_LANES:0] tx_data_out_n;
  logic up_wr;
  logic [LANE_AW-1:0] up_waddr;
  logic [LANE_AW-1:0] up_raddr;
  delay_tap_t up_wdata;
  delay_tap_t up_rdata;
  logic delay_rst;
  logic delay_locked;

  // checker side
  logic [NUM_LANES:0] exp_en;
  lvds_bit_pair_t [NUM_LANES:0] exp_pair;
  logic rd_en;
  delay_tap_t rd_exp;
  logic lock_exp;
  int test_id;
  logic test_done;
  logic run_done;
  int err_cnt;
  int chk_cnt;

  // model state
  model_ent_t model_q[$];
  delay_tap_t [NUM_LANES:0] tap_m;
  int cyc;
  int lock_at;
  integer seed;
  logic [31:0] r;
  logic [31:0] v;
  delay_tap_t val;

  always #50 tx_clk = ~tx_clk;
  assign up_clk    = tx_clk;
  assign delay_clk = tx_clk;

  lvds_tx_if #(
    .NUM_LANES         (NUM_LANES),
    .SINGLE_ENDED      (SINGLE_ENDED),
    .IODELAY_ENABLE    (IODELAY_ENABLE),
    .DELAY_CTRL_ENABLE (DELAY_CTRL_ENABLE),
    .LOCK_CYCLES       (LOCK_CYCLES)
  ) u_lvds_tx_if (
    .tx_clk        (tx_clk),
    .up_clk        (up_clk),
    .delay_clk     (delay_clk),
    .arst_n        (arst_n),
    .tx_valid      (tx_valid),
    .tx_sample     (tx_sample),
    .tx_data_out_p (tx_data_out_p),
    .tx_data_out_n (tx_data_out_n),
    .up_wr         (up_wr),
    .up_waddr      (up_waddr),
    .up_wdata      (up_wdata),
    .up_raddr      (up_raddr),
    .up_rdata      (up_rdata),
    .delay_rst     (delay_rst),
    .delay_locked  (delay_locked)
  );

  lvds_tx_checker #(
    .NUM_LANES    (NUM_LANES),
    .SINGLE_ENDED (SINGLE_ENDED)
  ) u_checker (
    .tx_clk        (tx_clk),
    .tx_data_out_p (tx_data_out_p),
    .tx_data_out_n (tx_data_out_n),
    .up_rdata      (up_rdata),
    .delay_locked  (delay_locked),
    .exp_en        (exp_en),
    .exp_pair      (exp_pair),
    .rd_en         (rd_en),
    .rd_exp        (rd_exp),
    .lock_exp      (lock_exp),
    .test_id       (test_id),
    .test_done     (test_done),
    .run_done      (run_done),
    .err_cnt       (err_cnt),
    .chk_cnt       (chk_cnt)
  );

  // **************************************************
  // cycle and model helpers
  // **************************************************

  // inputs change 5 ns after the edge, then the due pairs go to the checker
  task automatic next_cycle;
    model_ent_t ent;
    @(posedge tx_clk);
    #5;
    cyc    = cyc + 1;
    exp_en = '0;
    rd_en  = 1'b0;
    lock_exp = (DELAY_CTRL_ENABLE == 0) || (cyc >= lock_at);
    for (int j = model_q.size() - 1; j >= 0; j--) begin
      ent = model_q[j];
      if (ent.due == cyc) begin
        exp_en[ent.lane]   = 1'b1;
        exp_pair[ent.lane] = ent.pair;
        model_q.delete(j);
      end
    end
  endtask

  // formatter cycle, capture, oddr register, then the tap stages
  task automatic drive_sample(input logic valid, input logic [2*NUM_LANES-1:0] smp);
    model_ent_t ent;
    tx_valid  = valid;
    tx_sample = smp;
    for (int i = 0; i <= NUM_LANES; i++) begin
      ent.due  = cyc + 3 + tap_m[i];
      ent.lane = i;
      if (i == NUM_LANES) begin
        ent.pair.rise = valid;
        ent.pair.fall = 1'b0;
      end else begin
        ent.pair.rise = valid & smp[2*i+1];
        ent.pair.fall = valid & smp[2*i];
      end
      model_q.push_back(ent);
    end
    next_cycle();
  endtask

  task automatic send_random(input int n);
    repeat (n) begin
      r = $random(seed);
      v = $random(seed);
      drive_sample(v[0], r[2*NUM_LANES-1:0]);
    end
  endtask

  // also flushes the delay lines before a tap change
  task automatic send_idle(input int n);
    repeat (n) begin
      drive_sample(1'b0, '0);
    end
  endtask

  // a write only lands while locked and in range
  task automatic write_tap(input logic [LANE_AW-1:0] lane, input delay_tap_t t);
    up_wr    = 1'b1;
    up_waddr = lane;
    up_wdata = t;
    if (lock_exp && lane <= NUM_LANES && IODELAY_ENABLE == 1) begin
      tap_m[lane] = t;
    end
    next_cycle();
    up_wr = 1'b0;
  endtask

  // registered readback, checked one cycle after the address
  task automatic read_tap(input logic [LANE_AW-1:0] addr);
    up_raddr = addr;
    next_cycle();
    rd_en  = 1'b1;
    rd_exp = (addr <= NUM_LANES) ? tap_m[addr] : '0;
  endtask

  task automatic end_test;
    next_cycle();
    test_done = 1'b1;
    #1;
    test_done = 1'b0;
    test_id   = test_id + 1;
  endtask

  // **************************************************
  // test sequence
  // **************************************************

  initial begin
    seed      = 32'h3dfb_74a2;
    tx_clk    = 1'b0;
    arst_n    = 1'b0;
    tx_valid  = 1'b0;
    tx_sample = '0;
    up_wr     = 1'b0;
    up_waddr  = '0;
    up_wdata  = '0;
    up_raddr  = '0;
    delay_rst = 1'b1;
    exp_en    = '0;
    exp_pair  = '0;
    rd_en     = 1'b0;
    rd_exp    = '0;
    lock_exp  = (DELAY_CTRL_ENABLE == 0);
    test_id   = 0;
    test_done = 1'b0;
    run_done  = 1'b0;
    tap_m     = '0;
    cyc       = 0;
    lock_at   = 32'h7fff_ffff;

    repeat (5) next_cycle();
    arst_n = 1'b1;

    // reset_idle
    repeat (4) begin
      next_cycle();
      exp_en   = '1;
      exp_pair = '0;
      rd_en    = 1'b1;
      rd_exp   = '0;
    end
    end_test();

    // lock_gate, first write lands while delay_rst is still high
    r   = $random(seed);
    val = r[TAP_W-1:0] | delay_tap_t'(1);
    write_tap('0, val);
    read_tap('0);
    delay_rst = 1'b0;
    lock_at   = cyc + 1 + LOCK_CYCLES;
    repeat (LOCK_CYCLES + 2) next_cycle();
    write_tap('0, val);
    read_tap('0);
    write_tap('0, '0);
    read_tap('0);
    end_test();

    // stream_tap0
    send_random(N_SAMPLES);
    send_idle(40);
    end_test();

    // tap_readback
    for (int i = 0; i <= NUM_LANES; i++) begin
      r = $random(seed);
      write_tap(LANE_AW'(i), r[TAP_W-1:0]);
    end
    for (int i = 0; i <= NUM_LANES + 1; i++) begin
      read_tap(LANE_AW'(i));
    end
    end_test();

    // stream_delayed, drain covers the longest tap
    send_random(N_SAMPLES);
    send_idle(36);
    end_test();

    // relock, one cycle pulse on delay_rst
    delay_rst = 1'b1;
    lock_at   = cyc + 2 + LOCK_CYCLES;
    next_cycle();
    delay_rst = 1'b0;
    write_tap(LANE_AW'(1), ~tap_m[1]);
    read_tap(LANE_AW'(1));
    repeat (LOCK_CYCLES + 2) next_cycle();
    end_test();

    run_done = 1'b1;
    #1;
    if (err_cnt == 0 && chk_cnt > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((TEST_CYCLES + 200) * 100);
    $display("watchdog: run timed out after %0d cycles", TEST_CYCLES + 200);
    $display("test failed");
    $finish;
  end

endmodule

// File: lvds_tx_if.f
lvds_tx_pkg.sv
tx_frame_fmt.sv
lvds_out.sv
delay_ctrl.sv
up_delay_regs.sv
lvds_tx_if.sv
lvds_tx_checker.sv
tb_lvds_tx_if.sv
